/* stream_cfg.svh */
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

//////////////////////////////
// burst transfers
//////////////////////////////

// 32-bit words moved per burst in either direction
// input side holds back anything below one burst
`define STREAM_BURST_LEN 16

//////////////////////////////
// buffer sizes
//////////////////////////////

// input FIFO depth in packed 32-bit words
// power of two so the pointers wrap on their own
`define STREAM_IN_DEPTH 64

// output FIFO depth in 32-bit words
// must hold at least one burst
`define STREAM_OUT_DEPTH 64

// bulk memory depth in 32-bit words
// power of two so the circular addresses wrap on their own
`define STREAM_BULK_DEPTH 1024

`endif

/* stream_pkg.sv */
`include "stream_cfg.svh"

package stream_pkg;

	//////////////////////////////
	// data path words
	//////////////////////////////

	// one sample as written by the source
	typedef logic [15:0] sample_t;

	// two samples side by side
	// first-written sample sits in bits 15:0
	typedef logic [31:0] packed_t;

	//////////////////////////////
	// levels and counts
	//////////////////////////////

	// larger of the two FIFO depths
	localparam int fifo_depth_max = (`STREAM_IN_DEPTH > `STREAM_OUT_DEPTH) ?
		`STREAM_IN_DEPTH : `STREAM_OUT_DEPTH;

	// the bulk fill travels on the same level type
	localparam int lvl_depth = (fifo_depth_max > `STREAM_BULK_DEPTH) ?
		fifo_depth_max : `STREAM_BULK_DEPTH;

	// one extra bit so a completely full buffer is representable
	localparam int lvl_w = $clog2(lvl_depth) + 1;

	// fill level in 32-bit words
	typedef logic [lvl_w-1:0] fifo_lvl_t;

	// host-visible count in 16-bit words
	typedef logic [31:0] count_t;

endpackage

/* bulk_pkg.sv */
`include "stream_cfg.svh"

package bulk_pkg;

	//////////////////////////////
	// bulk memory addressing
	//////////////////////////////

	// word address bits for the bulk array
	localparam int addr_w = $clog2(`STREAM_BULK_DEPTH);

	// circular word address
	// increments wrap at the top of the array
	typedef logic [addr_w-1:0] bulk_addr_t;

	//////////////////////////////
	// burst control
	//////////////////////////////

	// one extra bit to reach burst length itself
	// the read burst needs that value for its drain cycle
	localparam int beat_w = $clog2(`STREAM_BURST_LEN) + 1;

	// beat index inside one burst
	typedef logic [beat_w-1:0] burst_cnt_t;

	// burst controller states
	typedef enum logic [1:0] {
		mover_idle,
		mover_write,
		mover_read
	} mover_state_e;

endpackage

/* sample_pack_fifo.sv */
`timescale 1ns/100ps

`include "stream_cfg.svh"

module sample_pack_fifo (
	input  logic                  ti_clk,
	input  logic                  reset,
	input  logic                  fifo_write_to,
	input  stream_pkg::sample_t   fifo_data_in,
	input  logic                  in_pop,
	output stream_pkg::packed_t   in_word,
	output stream_pkg::fifo_lvl_t in_level,
	output logic                  in_half_pending
);

	localparam int depth = `STREAM_IN_DEPTH;
	localparam int ptr_w = $clog2(depth);

	// packed word storage
	stream_pkg::packed_t mem [0:depth-1];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;

	// first sample of a pair waiting for its partner
	stream_pkg::sample_t low_half;

	logic full;
	logic push;

	assign full = (in_level == stream_pkg::fifo_lvl_t'(depth));

	// second sample of a pair completes a word
	// a full queue loses the whole pair
	assign push = fifo_write_to && in_half_pending && !full;

	// head word is shown directly
	// the mover takes it in the same cycle as in_pop
	assign in_word = mem[rd_ptr];

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (fifo_write_to && !in_half_pending) begin
			low_half <= fifo_data_in;
		end
		// newer sample goes in the high half
		if (push) begin
			mem[wr_ptr] <= {fifo_data_in, low_half};
		end
	end

	//////////////////////////////
	// pointers and level
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			in_level        <= '0;
			in_half_pending <= 1'b0;
		end else begin
			// every write flips between low and high half
			if (fifo_write_to) begin
				in_half_pending <= !in_half_pending;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (in_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// level in packed words
			case ({push, in_pop})
				2'b10:   in_level <= in_level + 1'b1;
				2'b01:   in_level <= in_level - 1'b1;
				default: in_level <= in_level;
			endcase
		end
	end

endmodule

/* burst_mover.sv */
`timescale 1ns/100ps

`include "stream_cfg.svh"

module burst_mover (
	input  logic                  ti_clk,
	input  logic                  reset,
	input  stream_pkg::fifo_lvl_t in_level,
	output logic                  in_pop,
	input  stream_pkg::packed_t   in_word,
	output logic                  ram_we,
	output bulk_pkg::bulk_addr_t  ram_waddr,
	output stream_pkg::packed_t   ram_wdata,
	output logic                  ram_re,
	output bulk_pkg::bulk_addr_t  ram_raddr,
	input  stream_pkg::packed_t   ram_rdata,
	output logic                  out_push,
	output stream_pkg::packed_t   out_word,
	input  stream_pkg::fifo_lvl_t out_level,
	output stream_pkg::fifo_lvl_t bulk_fill
);

	localparam int burst_len = `STREAM_BURST_LEN;
	localparam int out_depth = `STREAM_OUT_DEPTH;

	// last beat of a write burst
	localparam bulk_pkg::burst_cnt_t wr_last = bulk_pkg::burst_cnt_t'(burst_len - 1);
	// read burst runs one beat longer for the read latency
	localparam bulk_pkg::burst_cnt_t rd_last = bulk_pkg::burst_cnt_t'(burst_len);

	bulk_pkg::mover_state_e state;
	bulk_pkg::burst_cnt_t   beat;
	bulk_pkg::bulk_addr_t   wr_addr;
	bulk_pkg::bulk_addr_t   rd_addr;
	bulk_pkg::bulk_addr_t   addr_diff;

	logic can_write;
	logic can_read;
	logic re_d;

	//////////////////////////////
	// circular fill and start checks
	//////////////////////////////

	// modular difference of the two addresses
	// a lapped writer makes this wrong and nothing guards it
	assign addr_diff = wr_addr - rd_addr;
	assign bulk_fill = stream_pkg::fifo_lvl_t'(addr_diff);

	assign can_write = (in_level >= stream_pkg::fifo_lvl_t'(burst_len));

	// need a whole burst stored and a whole burst of room downstream
	assign can_read = (bulk_fill >= stream_pkg::fifo_lvl_t'(burst_len)) &&
		(out_level <= stream_pkg::fifo_lvl_t'(out_depth - burst_len));

	//////////////////////////////
	// strobes
	//////////////////////////////

	// write path is straight through from the input head
	assign in_pop    = (state == bulk_pkg::mover_write);
	assign ram_we    = in_pop;
	assign ram_waddr = wr_addr;
	assign ram_wdata = in_word;

	// no read on the drain beat
	assign ram_re    = (state == bulk_pkg::mover_read) && (beat != rd_last);
	assign ram_raddr = rd_addr;

	// read data lands one cycle after ram_re
	assign out_push = re_d;
	assign out_word = ram_rdata;

	//////////////////////////////
	// burst FSM
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			state   <= bulk_pkg::mover_idle;
			beat    <= '0;
			wr_addr <= '0;
			rd_addr <= '0;
			re_d    <= 1'b0;
		end else begin
			re_d <= ram_re;
			if (ram_we) begin
				wr_addr <= wr_addr + 1'b1;
			end
			if (ram_re) begin
				rd_addr <= rd_addr + 1'b1;
			end
			case (state)
				bulk_pkg::mover_idle: begin
					beat <= '0;
					// writes take priority over reads
					if (can_write) begin
						state <= bulk_pkg::mover_write;
					end else if (can_read) begin
						state <= bulk_pkg::mover_read;
					end
				end
				bulk_pkg::mover_write: begin
					beat <= beat + 1'b1;
					if (beat == wr_last) begin
						state <= bulk_pkg::mover_idle;
					end
				end
				bulk_pkg::mover_read: begin
					beat <= beat + 1'b1;
					// leave once the last word has been pushed
					if (beat == rd_last) begin
						state <= bulk_pkg::mover_idle;
					end
				end
				default: state <= bulk_pkg::mover_idle;
			endcase
		end
	end

endmodule

/* bulk_ram.sv */
`timescale 1ns/100ps

`include "stream_cfg.svh"

module bulk_ram (
	input  logic                 ti_clk,
	input  logic                 ram_we,
	input  bulk_pkg::bulk_addr_t ram_waddr,
	input  stream_pkg::packed_t  ram_wdata,
	input  logic                 ram_re,
	input  bulk_pkg::bulk_addr_t ram_raddr,
	output stream_pkg::packed_t  ram_rdata
);

	localparam int depth = `STREAM_BULK_DEPTH;

	// on-chip stand-in for the external SDRAM
	stream_pkg::packed_t mem [0:depth-1];

	// one write port
	always_ff @(posedge ti_clk) begin
		if (ram_we) begin
			mem[ram_waddr] <= ram_wdata;
		end
	end

	// registered read port
	// data valid the cycle after ram_re
	// output holds between reads
	always_ff @(posedge ti_clk) begin
		if (ram_re) begin
			ram_rdata <= mem[ram_raddr];
		end
	end

endmodule

/* host_out_fifo.sv */
`timescale 1ns/100ps

`include "stream_cfg.svh"

module host_out_fifo (
	input  logic                  ti_clk,
	input  logic                  reset,
	input  logic                  out_push,
	input  stream_pkg::packed_t   out_word,
	input  logic                  fifo_read_from,
	output stream_pkg::packed_t   fifo_data_out,
	output stream_pkg::fifo_lvl_t out_level,
	input  stream_pkg::count_t    usb3_blocksize,
	output logic                  fifo_out_rdy
);

	localparam int depth = `STREAM_OUT_DEPTH;
	localparam int ptr_w = $clog2(depth);

	stream_pkg::packed_t mem [0:depth-1];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;

	logic push;
	logic pop;

	// mover checks room before a burst so a full drop should not occur
	assign push = out_push && (out_level != stream_pkg::fifo_lvl_t'(depth));
	// empty read is ignored
	assign pop  = fifo_read_from && (out_level != '0);

	//////////////////////////////
	// storage and output word
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (push) begin
			mem[wr_ptr] <= out_word;
		end
		// output word only moves on a real pop
		// so an underflow repeats the last word
		if (pop) begin
			fifo_data_out <= mem[rd_ptr];
		end
	end

	//////////////////////////////
	// pointers, level, ready flag
	//////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			out_level    <= '0;
			fifo_out_rdy <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   out_level <= out_level + 1'b1;
				2'b01:   out_level <= out_level - 1'b1;
				default: out_level <= out_level;
			endcase
			// block ready against the registered level
			fifo_out_rdy <= (stream_pkg::count_t'(out_level) >= usb3_blocksize);
		end
	end

endmodule

/* fill_monitor.sv */
`timescale 1ns/100ps

module fill_monitor (
	input  logic                  ti_clk,
	input  logic                  reset,
	input  stream_pkg::fifo_lvl_t in_level,
	input  logic                  in_half_pending,
	input  stream_pkg::fifo_lvl_t bulk_fill,
	input  stream_pkg::fifo_lvl_t out_level,
	output stream_pkg::count_t    input_fifo_numwords,
	output stream_pkg::count_t    sdram_numwords,
	output stream_pkg::count_t    output_fifo_numwords,
	output stream_pkg::count_t    num_words_in_fifo
);

	stream_pkg::count_t in_cnt;
	stream_pkg::count_t bulk_cnt;
	stream_pkg::count_t out_cnt;

	// all counts in 16-bit words
	// each packed word holds two samples
	// plus the unpaired sample waiting on the input side
	assign in_cnt   = (stream_pkg::count_t'(in_level) << 1) +
		stream_pkg::count_t'(in_half_pending);
	assign bulk_cnt = stream_pkg::count_t'(bulk_fill) << 1;
	assign out_cnt  = stream_pkg::count_t'(out_level) << 1;

	// words in flight inside the mover are not counted
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			input_fifo_numwords  <= '0;
			sdram_numwords       <= '0;
			output_fifo_numwords <= '0;
			num_words_in_fifo    <= '0;
		end else begin
			input_fifo_numwords  <= in_cnt;
			sdram_numwords       <= bulk_cnt;
			output_fifo_numwords <= out_cnt;
			// total from the same levels so it matches the parts
			num_words_in_fifo    <= in_cnt + bulk_cnt + out_cnt;
		end
	end

endmodule

/* stream_buffer_top.sv */
`timescale 1ns/100ps

module stream_buffer_top (
	input  logic                ti_clk,
	input  logic                reset,
	input  logic                fifo_write_to,
	input  stream_pkg::sample_t fifo_data_in,
	input  logic                fifo_read_from,
	output stream_pkg::packed_t fifo_data_out,
	output logic                fifo_out_rdy,
	input  stream_pkg::count_t  usb3_blocksize,
	output stream_pkg::count_t  input_fifo_numwords,
	output stream_pkg::count_t  sdram_numwords,
	output stream_pkg::count_t  output_fifo_numwords,
	output stream_pkg::count_t  num_words_in_fifo
);

	// input side to mover
	stream_pkg::fifo_lvl_t in_level;
	logic                  in_pop;
	stream_pkg::packed_t   in_word;
	logic                  in_half_pending;

	// mover to bulk memory
	logic                  ram_we;
	bulk_pkg::bulk_addr_t  ram_waddr;
	stream_pkg::packed_t   ram_wdata;
	logic                  ram_re;
	bulk_pkg::bulk_addr_t  ram_raddr;
	stream_pkg::packed_t   ram_rdata;

	// mover to output side
	logic                  out_push;
	stream_pkg::packed_t   out_word;
	stream_pkg::fifo_lvl_t out_level;
	stream_pkg::fifo_lvl_t bulk_fill;

	//////////////////////////////
	// input side
	//////////////////////////////

	sample_pack_fifo u_pack (
		.ti_clk          (ti_clk),
		.reset           (reset),
		.fifo_write_to   (fifo_write_to),
		.fifo_data_in    (fifo_data_in),
		.in_pop          (in_pop),
		.in_word         (in_word),
		.in_level        (in_level),
		.in_half_pending (in_half_pending)
	);

	//////////////////////////////
	// processing
	//////////////////////////////

	burst_mover u_mover (
		.ti_clk    (ti_clk),
		.reset     (reset),
		.in_level  (in_level),
		.in_pop    (in_pop),
		.in_word   (in_word),
		.ram_we    (ram_we),
		.ram_waddr (ram_waddr),
		.ram_wdata (ram_wdata),
		.ram_re    (ram_re),
		.ram_raddr (ram_raddr),
		.ram_rdata (ram_rdata),
		.out_push  (out_push),
		.out_word  (out_word),
		.out_level (out_level),
		.bulk_fill (bulk_fill)
	);

	bulk_ram u_ram (
		.ti_clk    (ti_clk),
		.ram_we    (ram_we),
		.ram_waddr (ram_waddr),
		.ram_wdata (ram_wdata),
		.ram_re    (ram_re),
		.ram_raddr (ram_raddr),
		.ram_rdata (ram_rdata)
	);

	//////////////////////////////
	// output side
	//////////////////////////////

	host_out_fifo u_out (
		.ti_clk         (ti_clk),
		.reset          (reset),
		.out_push       (out_push),
		.out_word       (out_word),
		.fifo_read_from (fifo_read_from),
		.fifo_data_out  (fifo_data_out),
		.out_level      (out_level),
		.usb3_blocksize (usb3_blocksize),
		.fifo_out_rdy   (fifo_out_rdy)
	);

	fill_monitor u_mon (
		.ti_clk               (ti_clk),
		.reset                (reset),
		.in_level             (in_level),
		.in_half_pending      (in_half_pending),
		.bulk_fill            (bulk_fill),
		.out_level            (out_level),
		.input_fifo_numwords  (input_fifo_numwords),
		.sdram_numwords       (sdram_numwords),
		.output_fifo_numwords (output_fifo_numwords),
		.num_words_in_fifo    (num_words_in_fifo)
	);

endmodule

/* stream_buffer_tb.sv */
`timescale 1ns/100ps

`include "stream_cfg.svh"

module stream_buffer_tb;

	localparam int burst = `STREAM_BURST_LEN;
	localparam int quiet_len = 8 * burst;
	// drain gives up after this many cycles with no word to read
	localparam int idle_limit = 4 * burst;
	localparam int max_blocks = 8;
	localparam int rand_cycles = 800;

	// rough length of each test in cycles
	localparam int t1_len = 16;
	localparam int t2_len = max_blocks * 2 * burst + quiet_len + 4 * max_blocks * burst +
		idle_limit;
	localparam int t3_len = rand_cycles;
	localparam int t4_len = quiet_len + 4;
	localparam int t5_len = 8 * 4;
	localparam int t6_len = 4 * (rand_cycles / 2) + idle_limit + 8 * 3;
	localparam int timeout_cycles = 2 * (t1_len + t2_len + t3_len + t4_len + t5_len + t6_len);

	logic                ti_clk;
	logic                reset;
	logic                fifo_write_to;
	stream_pkg::sample_t fifo_data_in;
	logic                fifo_read_from;
	stream_pkg::packed_t fifo_data_out;
	logic                fifo_out_rdy;
	stream_pkg::count_t  usb3_blocksize;
	stream_pkg::count_t  input_fifo_numwords;
	stream_pkg::count_t  sdram_numwords;
	stream_pkg::count_t  output_fifo_numwords;
	stream_pkg::count_t  num_words_in_fifo;

	// reference model holds samples in write order and the last word the host saw
	stream_pkg::sample_t model_q [$];
	stream_pkg::packed_t last_word = '0;
	stream_pkg::count_t  block_size = 32'd16;

	logic [31:0] lfsr_state = 32'h51235fd3;
	int error_count = 0;
	int samples_written = 0;
	int words_read = 0;
	int empty_reads = 0;
	int cycle_count = 0;
	// read kind driven last cycle, checked one edge later
	int prev_read_kind = 0;
	int since_read = 8;

	stream_buffer_top uut (
		.ti_clk               (ti_clk),
		.reset                (reset),
		.fifo_write_to        (fifo_write_to),
		.fifo_data_in         (fifo_data_in),
		.fifo_read_from       (fifo_read_from),
		.fifo_data_out        (fifo_data_out),
		.fifo_out_rdy         (fifo_out_rdy),
		.usb3_blocksize       (usb3_blocksize),
		.input_fifo_numwords  (input_fifo_numwords),
		.sdram_numwords       (sdram_numwords),
		.output_fifo_numwords (output_fifo_numwords),
		.num_words_in_fifo    (num_words_in_fifo)
	);

	initial begin
		ti_clk = 1'b0;
		forever #4 ti_clk = ~ti_clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        bit_out;
		value = '0;
		for (int i = 0; i < n; i++) begin
			bit_out = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (bit_out) begin
				lfsr_state = lfsr_state ^ 32'h80200003;
			end
			value = {value[30:0], bit_out};
		end
		return value;
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error at %0d ns: %s = %h, expected %h", $time, sig, got, exp);
		error_count++;
	endtask

	task automatic report_problem(input string msg);
		$display("Problem at %0d ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (error_count == errs_before) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: fail, %0d errors", name, error_count - errs_before);
		end
	endtask

	// one clock of stimulus
	// rd_kind 0 no read, 1 read checked against the model, 2 read of an empty FIFO
	task automatic run_cycle(input logic wr, input stream_pkg::sample_t data, input int rd_kind);
		int                  check_kind;
		stream_pkg::packed_t expect_word;
		@(posedge ti_clk);
		fifo_write_to  <= wr;
		fifo_data_in   <= data;
		fifo_read_from <= (rd_kind != 0);
		usb3_blocksize <= block_size;
		if (wr) begin
			model_q.push_back(data);
			samples_written++;
		end
		check_kind = prev_read_kind;
		prev_read_kind = rd_kind;
		if (rd_kind != 0) begin
			since_read = 0;
		end else begin
			since_read++;
		end
		// a read sampled at the last edge shows its word from that edge on
		@(negedge ti_clk);
		if (check_kind == 1) begin
			if (model_q.size() < 2) begin
				report_problem("host read a word but the model holds fewer than two samples");
			end else begin
				// first-written sample in the low half
				expect_word = {model_q[1], model_q[0]};
				void'(model_q.pop_front());
				void'(model_q.pop_front());
				words_read++;
				if (fifo_data_out != expect_word) begin
					report_mismatch("fifo_data_out", fifo_data_out, expect_word);
				end
				last_word = expect_word;
			end
		end else if (check_kind == 2) begin
			empty_reads++;
			if (fifo_data_out != last_word) begin
				report_mismatch("fifo_data_out", fifo_data_out, last_word);
			end
		end
	endtask

	task automatic wait_quiet(input int n);
		repeat (n) run_cycle(1'b0, '0, 0);
	endtask

	// read while the count shows a word
	// reads are spaced so the registered count has caught up
	task automatic drain_output();
		int idle;
		idle = 0;
		while (idle < idle_limit) begin
			if (output_fifo_numwords >= 32'd2 && since_read >= 3) begin
				run_cycle(1'b0, '0, 1);
				idle = 0;
			end else begin
				run_cycle(1'b0, '0, 0);
				if (output_fifo_numwords < 32'd2) begin
					idle++;
				end
			end
		end
	endtask

	//////////////////////////////
	// watchdog
	//////////////////////////////

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge ti_clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		int                  errs;
		int                  blocks;
		int                  rd_kind;
		int                  moved;
		logic                wr_bit;
		logic                exp_rdy;
		stream_pkg::sample_t sample;
		fifo_write_to  <= 1'b0;
		fifo_data_in   <= '0;
		fifo_read_from <= 1'b0;
		usb3_blocksize <= block_size;
		reset          <= 1'b1;
		repeat (5) @(posedge ti_clk);
		reset <= 1'b0;

		// test 1 checks the flag and counts cleared by reset
		errs = error_count;
		wait_quiet(3);
		if (fifo_out_rdy != 1'b0) begin
			report_mismatch("fifo_out_rdy", 32'(fifo_out_rdy), 32'd0);
		end
		if (input_fifo_numwords != 0) begin
			report_mismatch("input_fifo_numwords", input_fifo_numwords, 0);
		end
		if (sdram_numwords != 0) begin
			report_mismatch("sdram_numwords", sdram_numwords, 0);
		end
		if (output_fifo_numwords != 0) begin
			report_mismatch("output_fifo_numwords", output_fifo_numwords, 0);
		end
		if (num_words_in_fifo != 0) begin
			report_mismatch("num_words_in_fifo", num_words_in_fifo, 0);
		end
		end_test("test 1 reset values", errs);

		// test 2 writes whole bursts, lets them settle and drains them in order
		errs = error_count;
		blocks = int'(rand_bits(3)) + 1;
		for (int i = 0; i < blocks * 2 * burst; i++) begin
			run_cycle(1'b1, stream_pkg::sample_t'(rand_bits(16)), 0);
		end
		wait_quiet(quiet_len);
		drain_output();
		if (model_q.size() != 0) begin
			report_problem($sformatf("%0d samples never reached the host", model_q.size()));
		end
		end_test("test 2 burst fill and drain", errs);

		// test 3 mixes random writes and reads with random gaps
		errs = error_count;
		for (int c = 0; c < rand_cycles; c++) begin
			wr_bit = (rand_bits(1) == 32'd1);
			sample = stream_pkg::sample_t'(rand_bits(16));
			rd_kind = 0;
			if (rand_bits(2) == 32'd0 && since_read >= 3 && output_fifo_numwords >= 32'd2) begin
				rd_kind = 1;
			end
			run_cycle(wr_bit, sample, rd_kind);
		end
		end_test("test 3 random traffic", errs);

		// test 4 checks the counts once traffic stops
		errs = error_count;
		wait_quiet(quiet_len);
		if (num_words_in_fifo != stream_pkg::count_t'(samples_written - 2 * words_read)) begin
			report_mismatch("num_words_in_fifo", num_words_in_fifo,
				stream_pkg::count_t'(samples_written - 2 * words_read));
		end
		// anything short of a burst stays on the input side
		if (input_fifo_numwords != stream_pkg::count_t'(samples_written % (2 * burst))) begin
			report_mismatch("input_fifo_numwords", input_fifo_numwords,
				stream_pkg::count_t'(samples_written % (2 * burst)));
		end
		// whole bursts past the input side sit in bulk memory or the output FIFO
		moved = samples_written - samples_written % (2 * burst) - 2 * words_read;
		if (sdram_numwords + output_fifo_numwords != stream_pkg::count_t'(moved)) begin
			report_mismatch("sdram_numwords + output_fifo_numwords",
				sdram_numwords + output_fifo_numwords, stream_pkg::count_t'(moved));
		end
		end_test("test 4 quiet counts", errs);

		// test 5 compares the block-ready flag with the level in 32-bit words
		errs = error_count;
		for (int t = 0; t < 8; t++) begin
			if (t == 0) begin
				block_size = output_fifo_numwords >> 1;
			end else if (t == 1) begin
				block_size = (output_fifo_numwords >> 1) + 32'd1;
			end else begin
				block_size = rand_bits(7);
			end
			wait_quiet(3);
			exp_rdy = ((output_fifo_numwords >> 1) >= block_size);
			if (fifo_out_rdy != exp_rdy) begin
				report_mismatch("fifo_out_rdy", 32'(fifo_out_rdy), 32'(exp_rdy));
			end
		end
		end_test("test 5 block ready flag", errs);

		// test 6 drains what is left and then reads an empty FIFO
		errs = error_count;
		drain_output();
		// every stored burst has moved on to the host
		if (sdram_numwords != 0) begin
			report_mismatch("sdram_numwords", sdram_numwords, 0);
		end
		for (int r = 0; r < 8; r++) begin
			run_cycle(1'b0, '0, 2);
			wait_quiet(2);
		end
		if (output_fifo_numwords != 0) begin
			report_mismatch("output_fifo_numwords", output_fifo_numwords, 0);
		end
		end_test("test 6 empty reads", errs);

		$display("errors %0d, samples written %0d, words read %0d, empty reads %0d",
			error_count, samples_written, words_read, empty_reads);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+.
stream_pkg.sv
bulk_pkg.sv
sample_pack_fifo.sv
burst_mover.sv
bulk_ram.sv
host_out_fifo.sv
fill_monitor.sv
stream_buffer_top.sv
stream_buffer_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = stream_buffer_tb
FILELIST  = files.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
